// File: Bender.yml
package:
  name: dhcp_client

sources:
  - include_dirs:
      - hw
    files:
      - hw/dhcp_client_pkg.sv
      - hw/dhcp_prng.sv
      - hw/dhcp_retry_ctl.sv
      - hw/dhcp_client_core.sv
      - hw/dhcp_tx_fifo.sv
      - hw/dhcp_frame_builder.sv
      - hw/dhcp_client_top.sv
  - target: simulation
    include_dirs:
      - hw
      - tb
    files:
      - tb/tb_dhcp_client.sv

// File: dhcp_client.f
+incdir+hw
+incdir+tb
hw/dhcp_client_pkg.sv
hw/dhcp_prng.sv
hw/dhcp_retry_ctl.sv
hw/dhcp_client_core.sv
hw/dhcp_tx_fifo.sv
hw/dhcp_frame_builder.sv
hw/dhcp_client_top.sv
tb/tb_dhcp_client.sv

// File: hw/dhcp_client_core.sv
`timescale 1ns/10ps

module dhcp_client_core (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       run,
  input  logic                       attempt_rst,
  input  dhcp_client_pkg::xid_t      xid_rand,
  input  dhcp_client_pkg::ipv4_id_t  id_rand,
  input  dhcp_client_pkg::ipv4_t     pref_ip,
  input  logic                       rx_val,
  input  dhcp_client_pkg::dhcp_op_e  rx_op,
  input  dhcp_client_pkg::xid_t      rx_xid,
  input  dhcp_client_pkg::dhcp_msg_e rx_msg_type,
  input  dhcp_client_pkg::ipv4_t     rx_yiaddr,
  input  dhcp_client_pkg::ipv4_t     rx_siaddr,
  input  logic                       rx_router_pres,
  input  dhcp_client_pkg::ipv4_t     rx_router,
  input  logic                       rx_mask_pres,
  input  dhcp_client_pkg::ipv4_t     rx_mask,
  output logic                       msg_push,
  output dhcp_client_pkg::dhcp_msg_e msg_type,
  output dhcp_client_pkg::xid_t      msg_xid,
  output dhcp_client_pkg::ipv4_t     msg_req_ip,
  output dhcp_client_pkg::ipv4_t     msg_srv_id,
  output dhcp_client_pkg::ipv4_id_t  msg_ipv4_id,
  output logic                       success,
  output dhcp_client_pkg::ipv4_t     assig_ip,
  output dhcp_client_pkg::ipv4_t     router,
  output logic                       router_val,
  output dhcp_client_pkg::ipv4_t     subnet_mask,
  output logic                       subnet_mask_val
);

  import dhcp_client_pkg::*;

  dhcp_state_e state;
  dhcp_msg_e   expect_type;
  xid_t        xid_q;
  ipv4_id_t    ipv4_id_q;
  ipv4_t       offered_ip;
  ipv4_t       server_ip;
  logic        done;
  logic        rx_match;

  assign expect_type = (state == st_ack) ? msg_ack : msg_offer;

  // reply to our own transaction of the expected kind
  assign rx_match = rx_val && (rx_op == op_boot_reply) && (rx_xid == xid_q) &&
                    (rx_msg_type == expect_type);

  // message handed to the FIFO while in discover or request
  assign msg_push    = (state == st_discover) || (state == st_request);
  assign msg_type    = (state == st_request) ? msg_request : msg_discover;
  assign msg_xid     = (state == st_discover) ? xid_rand : xid_q;
  assign msg_req_ip  = (state == st_request) ? offered_ip : pref_ip;
  assign msg_srv_id  = (state == st_request) ? server_ip : '0;
  assign msg_ipv4_id = (state == st_discover) ? id_rand : ipv4_id_q + 1'b1;

  always_ff @(posedge clk) begin
    if (rst || attempt_rst) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (run && !done) begin
            state <= st_discover;
          end
        end
        st_discover: begin
          state <= st_offer;
        end
        st_offer: begin
          if (rx_match) begin
            state <= st_request;
          end
        end
        st_request: begin
          state <= st_ack;
        end
        st_ack: begin
          if (rx_match) begin
            state <= st_idle;
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // done blocks a restart until run drops
  always_ff @(posedge clk) begin
    if (rst) begin
      success         <= 1'b0;
      router_val      <= 1'b0;
      subnet_mask_val <= 1'b0;
      done            <= 1'b0;
    end else if (!run) begin
      done <= 1'b0;
    end else if (state == st_idle && !done) begin
      success         <= 1'b0;
      router_val      <= 1'b0;
      subnet_mask_val <= 1'b0;
    end else if (state == st_ack && rx_match && !attempt_rst) begin
      success         <= 1'b1;
      done            <= 1'b1;
      router_val      <= rx_router_pres;
      subnet_mask_val <= rx_mask_pres;
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_discover) begin
      xid_q     <= xid_rand;
      ipv4_id_q <= id_rand;
    end
    if (state == st_offer && rx_match) begin
      offered_ip <= rx_yiaddr;
      server_ip  <= rx_siaddr;
    end
    if (state == st_ack && rx_match) begin
      assig_ip <= rx_yiaddr;
      if (rx_router_pres) begin
        router <= rx_router;
      end
      if (rx_mask_pres) begin
        subnet_mask <= rx_mask;
      end
    end
  end

  // sends only while an attempt is live
  a_push_in_run: assert property (@(posedge clk) disable iff (rst)
    msg_push |-> run && !attempt_rst);

endmodule

// File: hw/dhcp_client_defines.svh
`ifndef DHCP_CLIENT_DEFINES_SVH
`define DHCP_CLIENT_DEFINES_SVH

// cycles allowed for one discover..ack attempt
`define DHCP_TIMEOUT_TICKS 4000

// further attempts after the first
`define DHCP_RETRIES 3

`define DHCP_MAC_ADDR 48'h02_00_5e_10_20_30

// messages held between core and frame builder
`define DHCP_TX_DEPTH 2

// fixed BOOTP header values
`define DHCP_COOKIE      32'h6382_5363
`define DHCP_FLAGS_BCAST 16'h8000
`define DHCP_HTYPE       8'd1
`define DHCP_HLEN        8'd6

// option codes
`define DHCP_OPT_MSG_TYPE 8'd53
`define DHCP_OPT_REQ_IP   8'd50
`define DHCP_OPT_SRV_ID   8'd54
`define DHCP_OPT_END      8'd255

`endif

// File: hw/dhcp_client_pkg.sv
package dhcp_client_pkg;

  // first octet in the top byte
  typedef logic [31:0] ipv4_t;

  typedef logic [47:0] mac_t;

  typedef logic [31:0] xid_t;

  typedef logic [15:0] ipv4_id_t;

  // option 53 values
  typedef enum logic [7:0] {
    msg_discover = 8'd1,
    msg_offer    = 8'd2,
    msg_request  = 8'd3,
    msg_ack      = 8'd5
  } dhcp_msg_e;

  // BOOTP op field
  typedef enum logic [7:0] {
    op_boot_request = 8'd1,
    op_boot_reply   = 8'd2
  } dhcp_op_e;

  // client FSM
  typedef enum logic [2:0] {
    st_idle,
    st_discover,
    st_offer,
    st_request,
    st_ack
  } dhcp_state_e;

endpackage

// File: hw/dhcp_client_top.sv
`timescale 1ns/10ps

module dhcp_client_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start,
  input  dhcp_client_pkg::ipv4_t     pref_ip,
  input  logic                       rx_val,
  input  dhcp_client_pkg::dhcp_op_e  rx_op,
  input  dhcp_client_pkg::xid_t      rx_xid,
  input  dhcp_client_pkg::dhcp_msg_e rx_msg_type,
  input  dhcp_client_pkg::ipv4_t     rx_yiaddr,
  input  dhcp_client_pkg::ipv4_t     rx_siaddr,
  input  logic                       rx_router_pres,
  input  dhcp_client_pkg::ipv4_t     rx_router,
  input  logic                       rx_mask_pres,
  input  dhcp_client_pkg::ipv4_t     rx_mask,
  output logic                       frame_val,
  output logic [31:0]                frame_word,
  output logic                       frame_last,
  output dhcp_client_pkg::ipv4_id_t  frame_ipv4_id,
  output logic                       ready,
  output logic                       success,
  output logic                       fail,
  output dhcp_client_pkg::ipv4_t     assig_ip,
  output dhcp_client_pkg::ipv4_t     router,
  output logic                       router_val,
  output dhcp_client_pkg::ipv4_t     subnet_mask,
  output logic                       subnet_mask_val
);

  import dhcp_client_pkg::*;

  logic      run;
  logic      attempt_rst;
  xid_t      xid_rand;
  ipv4_id_t  id_rand;
  logic      msg_push;
  dhcp_msg_e msg_type;
  xid_t      msg_xid;
  ipv4_t     msg_req_ip;
  ipv4_t     msg_srv_id;
  ipv4_id_t  msg_ipv4_id;
  dhcp_msg_e head_type;
  xid_t      head_xid;
  ipv4_t     head_req_ip;
  ipv4_t     head_srv_id;
  ipv4_id_t  head_ipv4_id;
  logic      not_empty;
  logic      pop;

  dhcp_retry_ctl i_retry_ctl (
    .clk         (clk),
    .rst         (rst),
    .start       (start),
    .success     (success),
    .run         (run),
    .attempt_rst (attempt_rst),
    .fail        (fail),
    .ready       (ready)
  );

  dhcp_prng #(.W(32), .POLY(32'h8020_0003)) i_prng_xid (
    .clk (clk),
    .rst (rst),
    .res (xid_rand)
  );

  dhcp_prng #(.W(16), .POLY(16'hface)) i_prng_id (
    .clk (clk),
    .rst (rst),
    .res (id_rand)
  );

  dhcp_client_core i_core (
    .clk             (clk),
    .rst             (rst),
    .run             (run),
    .attempt_rst     (attempt_rst),
    .xid_rand        (xid_rand),
    .id_rand         (id_rand),
    .pref_ip         (pref_ip),
    .rx_val          (rx_val),
    .rx_op           (rx_op),
    .rx_xid          (rx_xid),
    .rx_msg_type     (rx_msg_type),
    .rx_yiaddr       (rx_yiaddr),
    .rx_siaddr       (rx_siaddr),
    .rx_router_pres  (rx_router_pres),
    .rx_router       (rx_router),
    .rx_mask_pres    (rx_mask_pres),
    .rx_mask         (rx_mask),
    .msg_push        (msg_push),
    .msg_type        (msg_type),
    .msg_xid         (msg_xid),
    .msg_req_ip      (msg_req_ip),
    .msg_srv_id      (msg_srv_id),
    .msg_ipv4_id     (msg_ipv4_id),
    .success         (success),
    .assig_ip        (assig_ip),
    .router          (router),
    .router_val      (router_val),
    .subnet_mask     (subnet_mask),
    .subnet_mask_val (subnet_mask_val)
  );

  dhcp_tx_fifo i_fifo (
    .clk          (clk),
    .rst          (rst),
    .push         (msg_push),
    .pop          (pop),
    .msg_type     (msg_type),
    .msg_xid      (msg_xid),
    .msg_req_ip   (msg_req_ip),
    .msg_srv_id   (msg_srv_id),
    .msg_ipv4_id  (msg_ipv4_id),
    .head_type    (head_type),
    .head_xid     (head_xid),
    .head_req_ip  (head_req_ip),
    .head_srv_id  (head_srv_id),
    .head_ipv4_id (head_ipv4_id),
    .not_empty    (not_empty)
  );

  dhcp_frame_builder i_builder (
    .clk           (clk),
    .rst           (rst),
    .not_empty     (not_empty),
    .head_type     (head_type),
    .head_xid      (head_xid),
    .head_req_ip   (head_req_ip),
    .head_srv_id   (head_srv_id),
    .head_ipv4_id  (head_ipv4_id),
    .pop           (pop),
    .frame_val     (frame_val),
    .frame_word    (frame_word),
    .frame_last    (frame_last),
    .frame_ipv4_id (frame_ipv4_id)
  );

endmodule

// File: hw/dhcp_frame_builder.sv
`timescale 1ns/10ps
`include "dhcp_client_defines.svh"

module dhcp_frame_builder (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       not_empty,
  input  dhcp_client_pkg::dhcp_msg_e head_type,
  input  dhcp_client_pkg::xid_t      head_xid,
  input  dhcp_client_pkg::ipv4_t     head_req_ip,
  input  dhcp_client_pkg::ipv4_t     head_srv_id,
  input  dhcp_client_pkg::ipv4_id_t  head_ipv4_id,
  output logic                       pop,
  output logic                       frame_val,
  output logic [31:0]                frame_word,
  output logic                       frame_last,
  output dhcp_client_pkg::ipv4_id_t  frame_ipv4_id
);

  import dhcp_client_pkg::*;

  localparam mac_t client_mac = `DHCP_MAC_ADDR;

  logic       busy;
  logic [3:0] word_cnt;
  logic [3:0] last_idx;
  logic       is_req;
  dhcp_msg_e  f_type;
  xid_t       f_xid;
  ipv4_t      f_req_ip;
  ipv4_t      f_srv_id;

  assign pop        = !busy && not_empty;
  assign is_req     = (f_type == msg_request);
  // request carries the extra server id option
  assign last_idx   = is_req ? 4'd13 : 4'd12;
  assign frame_val  = busy;
  assign frame_last = busy && (word_cnt == last_idx);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy     <= 1'b0;
      word_cnt <= '0;
    end else if (pop) begin
      busy     <= 1'b1;
      word_cnt <= '0;
    end else if (frame_last) begin
      busy <= 1'b0;
    end else if (busy) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      f_type        <= head_type;
      f_xid         <= head_xid;
      f_req_ip      <= head_req_ip;
      f_srv_id      <= head_srv_id;
      frame_ipv4_id <= head_ipv4_id;
    end
  end

  always_comb begin
    case (word_cnt)
      4'd0:    frame_word = {8'(op_boot_request), `DHCP_HTYPE, `DHCP_HLEN, 8'd0};
      4'd1:    frame_word = f_xid;
      4'd2:    frame_word = {16'd0, `DHCP_FLAGS_BCAST};
      4'd7:    frame_word = client_mac[47:16];
      4'd8:    frame_word = {client_mac[15:0], 16'd0};
      4'd9:    frame_word = `DHCP_COOKIE;
      // byte packed options from here on
      4'd10:   frame_word = {`DHCP_OPT_MSG_TYPE, 8'd1, 8'(f_type), `DHCP_OPT_REQ_IP};
      4'd11:   frame_word = {8'd4, f_req_ip[31:8]};
      4'd12:   frame_word = is_req ? {f_req_ip[7:0], `DHCP_OPT_SRV_ID, 8'd4, f_srv_id[31:24]}
                                   : {f_req_ip[7:0], `DHCP_OPT_END, 16'd0};
      4'd13:   frame_word = {f_srv_id[23:0], `DHCP_OPT_END};
      // ciaddr, yiaddr, siaddr, giaddr
      default: frame_word = '0;
    endcase
  end

  // frame length is defined for discover and request only
  a_head_type: assert property (@(posedge clk) disable iff (rst)
    pop |-> (head_type inside {msg_discover, msg_request}));

endmodule

// File: hw/dhcp_prng.sv
`timescale 1ns/10ps

module dhcp_prng #(
  parameter int unsigned     W    = 32,
  parameter logic [W-1:0]    POLY = 32'h8020_0003
) (
  input  logic         clk,
  input  logic         rst,
  output logic [W-1:0] res
);

  logic [W-1:0] lfsr;
  logic [W-1:0] taps;

  // feedback mask applied when the bit shifted out is set
  assign taps = lfsr[0] ? POLY : '0;

  always_ff @(posedge clk) begin
    if (rst) begin
      // any nonzero seed works
      lfsr <= {W{1'b1}};
    end else begin
      lfsr <= (lfsr >> 1) ^ taps;
    end
  end

  assign res = lfsr;

endmodule

// File: hw/dhcp_retry_ctl.sv
`timescale 1ns/10ps
`include "dhcp_client_defines.svh"

module dhcp_retry_ctl (
  input  logic clk,
  input  logic rst,
  input  logic start,
  input  logic success,
  output logic run,
  output logic attempt_rst,
  output logic fail,
  output logic ready
);

  localparam int tmr_w = $clog2(`DHCP_TIMEOUT_TICKS);
  localparam int try_w = $clog2(`DHCP_RETRIES + 1);

  logic [tmr_w-1:0] tmr_cnt;
  logic [try_w-1:0] try_cnt;
  logic             run_q;
  logic             expire;

  assign ready  = fail | success;
  assign expire = run && (tmr_cnt == tmr_w'(`DHCP_TIMEOUT_TICKS - 1));

  // attempt timer reloads on each expiry
  always_ff @(posedge clk) begin
    if (rst || !run || expire) begin
      tmr_cnt <= '0;
    end else begin
      tmr_cnt <= tmr_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run         <= 1'b0;
      run_q       <= 1'b0;
      attempt_rst <= 1'b0;
      fail        <= 1'b0;
      try_cnt     <= '0;
    end else begin
      run_q       <= run;
      attempt_rst <= expire;
      if (start && !run) begin
        run     <= 1'b1;
        fail    <= 1'b0;
        try_cnt <= '0;
      // success from the previous run is still visible in the first cycle
      end else if (ready && run_q) begin
        run <= 1'b0;
      end else if (expire) begin
        if (try_cnt == try_w'(`DHCP_RETRIES)) begin
          fail <= 1'b1;
        end else begin
          try_cnt <= try_cnt + 1'b1;
        end
      end
    end
  end

  a_fail_xor_success: assert property (@(posedge clk) disable iff (rst)
    !(fail && success));

endmodule

// File: hw/dhcp_tx_fifo.sv
`timescale 1ns/10ps
`include "dhcp_client_defines.svh"

module dhcp_tx_fifo (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push,
  input  logic                       pop,
  input  dhcp_client_pkg::dhcp_msg_e msg_type,
  input  dhcp_client_pkg::xid_t      msg_xid,
  input  dhcp_client_pkg::ipv4_t     msg_req_ip,
  input  dhcp_client_pkg::ipv4_t     msg_srv_id,
  input  dhcp_client_pkg::ipv4_id_t  msg_ipv4_id,
  output dhcp_client_pkg::dhcp_msg_e head_type,
  output dhcp_client_pkg::xid_t      head_xid,
  output dhcp_client_pkg::ipv4_t     head_req_ip,
  output dhcp_client_pkg::ipv4_t     head_srv_id,
  output dhcp_client_pkg::ipv4_id_t  head_ipv4_id,
  output logic                       not_empty
);

  import dhcp_client_pkg::*;

  localparam int depth = `DHCP_TX_DEPTH;
  localparam int aw    = (depth > 1) ? $clog2(depth) : 1;
  localparam int cw    = $clog2(depth + 1);

  dhcp_msg_e type_mem  [depth];
  xid_t      xid_mem   [depth];
  ipv4_t     req_mem   [depth];
  ipv4_t     srv_mem   [depth];
  ipv4_id_t  id_mem    [depth];

  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [cw-1:0] count;

  always_ff @(posedge clk) begin
    if (push) begin
      type_mem[wr_ptr] <= msg_type;
      xid_mem[wr_ptr]  <= msg_xid;
      req_mem[wr_ptr]  <= msg_req_ip;
      srv_mem[wr_ptr]  <= msg_srv_id;
      id_mem[wr_ptr]   <= msg_ipv4_id;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_type    = type_mem[rd_ptr];
  assign head_xid     = xid_mem[rd_ptr];
  assign head_req_ip  = req_mem[rd_ptr];
  assign head_srv_id  = srv_mem[rd_ptr];
  assign head_ipv4_id = id_mem[rd_ptr];
  assign not_empty    = (count != '0);

  // producer never outruns the builder
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    push |-> (count != cw'(depth)));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> not_empty);

endmodule

// File: tb/dhcp_tb_server.svh
`ifndef DHCP_TB_SERVER_SVH
`define DHCP_TB_SERVER_SVH

// last frame seen on the DUT output and the frame the server expects
logic [31:0] frame_buf [16];
int          frame_len;
ipv4_id_t    frame_id;
logic [31:0] exp_buf [16];
int          exp_len;

// fields decoded from the last frame
logic [7:0]  dec_type;
xid_t        dec_xid;
ipv4_t       dec_req_ip;
ipv4_t       dec_srv_id;

task automatic collect_frame(input string what, output bit ok);
  int  n;
  bit  done;
  n    = 0;
  done = 0;
  ok   = 1;
  frame_len = 0;
  while (!frame_val && n < frame_wait) begin
    @(posedge clk);
    n++;
  end
  if (!frame_val) begin
    report_timeout({what, " frame"});
    ok = 0;
    return;
  end
  frame_id = frame_ipv4_id;
  while (!done) begin
    if (!frame_val) begin
      $display("%s frame has a gap after word %0d", what, frame_len);
      errors++;
      ok   = 0;
      done = 1;
    end else begin
      frame_buf[frame_len] = frame_word;
      check_word("frame_ipv4_id", frame_ipv4_id, frame_id);
      frame_len++;
      if (frame_last) begin
        done = 1;
      end else if (frame_len == 16) begin
        $display("%s frame runs past 16 words without frame_last", what);
        errors++;
        ok   = 0;
        done = 1;
      end else begin
        @(posedge clk);
      end
    end
  end
  // fixed word positions of the options
  dec_type   = frame_buf[10][15:8];
  dec_xid    = frame_buf[1];
  dec_req_ip = {frame_buf[11][23:0], frame_buf[12][31:24]};
  dec_srv_id = {frame_buf[12][7:0], frame_buf[13][31:8]};
endtask

task automatic build_expected(input logic [7:0] mtype, input xid_t xid,
                              input ipv4_t req_ip, input ipv4_t srv_id);
  logic [7:0] opt [16];
  mac_t       mac;
  int         nb;
  int         i;
  mac = `DHCP_MAC_ADDR;
  for (i = 0; i < 16; i++) begin
    opt[i]     = 8'h00;
    exp_buf[i] = 32'h0;
  end
  // op, htype, hlen, hops
  exp_buf[0] = {8'd1, 8'd1, 8'd6, 8'd0};
  exp_buf[1] = xid;
  exp_buf[2] = {16'h0000, `DHCP_FLAGS_BCAST};
  exp_buf[7] = mac[47:16];
  exp_buf[8] = {mac[15:0], 16'h0000};
  exp_buf[9] = `DHCP_COOKIE;
  opt[0] = 8'd53;
  opt[1] = 8'd1;
  opt[2] = mtype;
  opt[3] = 8'd50;
  opt[4] = 8'd4;
  for (i = 0; i < 4; i++) begin
    opt[5 + i] = req_ip[31 - 8*i -: 8];
  end
  nb = 9;
  if (mtype == msg_request) begin
    opt[9]  = 8'd54;
    opt[10] = 8'd4;
    for (i = 0; i < 4; i++) begin
      opt[11 + i] = srv_id[31 - 8*i -: 8];
    end
    nb = 15;
  end
  opt[nb] = 8'd255;
  nb++;
  exp_len = 10 + (nb + 3) / 4;
  for (i = 10; i < exp_len; i++) begin
    exp_buf[i] = {opt[4*(i-10)], opt[4*(i-10)+1], opt[4*(i-10)+2], opt[4*(i-10)+3]};
  end
endtask

task automatic compare_frame(input string what);
  int i;
  check_word({"frame length of ", what}, frame_len, exp_len);
  for (i = 0; i < exp_len && i < frame_len; i++) begin
    check_word($sformatf("frame_word %s[%0d]", what, i), frame_buf[i], exp_buf[i]);
  end
endtask

// window in which no frame may start
task automatic expect_quiet(input string what, input int cycles);
  int i;
  bit seen;
  seen = 0;
  for (i = 0; i < cycles; i++) begin
    @(posedge clk);
    if (frame_val) begin
      seen = 1;
    end
  end
  if (seen) begin
    $display("a frame was sent after %s", what);
    errors++;
  end
endtask

task automatic send_reply(input dhcp_op_e op, input xid_t xid, input dhcp_msg_e mtype,
                          input ipv4_t yiaddr, input ipv4_t siaddr,
                          input bit rpres, input ipv4_t rtr,
                          input bit mpres, input ipv4_t msk);
  @(posedge clk);
  rx_val         <= 1'b1;
  rx_op          <= op;
  rx_xid         <= xid;
  rx_msg_type    <= mtype;
  rx_yiaddr      <= yiaddr;
  rx_siaddr      <= siaddr;
  rx_router_pres <= rpres;
  rx_router      <= rtr;
  rx_mask_pres   <= mpres;
  rx_mask        <= msk;
  @(posedge clk);
  rx_val <= 1'b0;
endtask

`endif

// File: tb/tb_dhcp_client.sv
`timescale 1ns/10ps
`include "dhcp_client_defines.svh"

module tb_dhcp_client;

  import dhcp_client_pkg::*;

  localparam int frame_wait = 200;
  localparam int fail_wait  = (`DHCP_RETRIES + 1) * `DHCP_TIMEOUT_TICKS + 500;

  logic        clk;
  logic        rst;
  logic        start;
  ipv4_t       pref_ip;
  logic        rx_val;
  dhcp_op_e    rx_op;
  xid_t        rx_xid;
  dhcp_msg_e   rx_msg_type;
  ipv4_t       rx_yiaddr;
  ipv4_t       rx_siaddr;
  logic        rx_router_pres;
  ipv4_t       rx_router;
  logic        rx_mask_pres;
  ipv4_t       rx_mask;
  logic        frame_val;
  logic [31:0] frame_word;
  logic        frame_last;
  ipv4_id_t    frame_ipv4_id;
  logic        ready;
  logic        success;
  logic        fail;
  ipv4_t       assig_ip;
  ipv4_t       router;
  logic        router_val;
  ipv4_t       subnet_mask;
  logic        subnet_mask_val;

  integer seed;
  int     errors;
  int     checks;
  int     tests_run;
  int     tests_failed;
  bit     aborted;

  dhcp_client_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_ip(input string name, input ipv4_t got, input ipv4_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout while waiting for %s", what);
    errors++;
    aborted = 1;
  endtask

  `include "dhcp_tb_server.svh"

  task automatic pulse_start(input ipv4_t pref);
    repeat (4) @(posedge clk);
    start   <= 1'b1;
    pref_ip <= pref;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic run_lease(input bit spurious, input bit rpres, input bit mpres);
    ipv4_t    pref;
    ipv4_t    offer_ip;
    ipv4_t    srv_ip;
    ipv4_t    rtr;
    ipv4_t    msk;
    xid_t     xid;
    ipv4_id_t next_id;
    int       kind;
    bit       ok;
    pref     = $random(seed);
    offer_ip = $random(seed);
    srv_ip   = $random(seed);
    rtr      = $random(seed);
    msk      = $random(seed);
    pulse_start(pref);
    @(posedge clk);
    check_flag("fail", fail, 1'b0);
    collect_frame("discover", ok);
    if (!ok) begin
      return;
    end
    check_flag("success", success, 1'b0);
    check_word("discover msg_type", dec_type, msg_discover);
    check_ip("discover requested ip", dec_req_ip, pref);
    build_expected(msg_discover, dec_xid, pref, 32'h0);
    compare_frame("discover");
    xid     = dec_xid;
    next_id = frame_id + 16'd1;
    if (spurious) begin
      send_reply(op_boot_reply, xid ^ ($random(seed) | 32'h1), msg_offer, offer_ip, srv_ip,
                 1'b0, 32'h0, 1'b0, 32'h0);
      expect_quiet("an offer with a wrong xid", 8);
      send_reply(op_boot_request, xid, msg_offer, offer_ip, srv_ip, 1'b0, 32'h0, 1'b0, 32'h0);
      expect_quiet("an offer with the request op", 8);
      send_reply(op_boot_reply, xid, msg_ack, offer_ip, srv_ip, 1'b0, 32'h0, 1'b0, 32'h0);
      expect_quiet("an ack in place of the offer", 8);
    end
    send_reply(op_boot_reply, xid, msg_offer, offer_ip, srv_ip, 1'b0, 32'h0, 1'b0, 32'h0);
    collect_frame("request", ok);
    if (!ok) begin
      return;
    end
    check_word("request msg_type", dec_type, msg_request);
    check_word("request xid", dec_xid, xid);
    check_ip("request requested ip", dec_req_ip, offer_ip);
    check_ip("request server id", dec_srv_id, srv_ip);
    check_word("request frame_ipv4_id", frame_id, next_id);
    build_expected(msg_request, xid, offer_ip, srv_ip);
    compare_frame("request");
    if (spurious) begin
      kind = $unsigned($random(seed)) % 3;
      case (kind)
        0: send_reply(op_boot_reply, xid ^ 32'h8000_0000, msg_ack, offer_ip, srv_ip,
                      rpres, rtr, mpres, msk);
        1: send_reply(op_boot_request, xid, msg_ack, offer_ip, srv_ip, rpres, rtr, mpres, msk);
        default: send_reply(op_boot_reply, xid, msg_offer, offer_ip, srv_ip,
                            rpres, rtr, mpres, msk);
      endcase
      // success would show one cycle after the strobe
      @(posedge clk);
      check_flag("success", success, 1'b0);
    end
    send_reply(op_boot_reply, xid, msg_ack, offer_ip, srv_ip, rpres, rtr, mpres, msk);
    // one cycle after the ack strobe
    @(posedge clk);
    check_flag("success", success, 1'b1);
    check_flag("ready", ready, 1'b1);
    check_flag("fail", fail, 1'b0);
    check_ip("assig_ip", assig_ip, offer_ip);
    check_flag("router_val", router_val, rpres);
    if (rpres) begin
      check_ip("router", router, rtr);
    end
    check_flag("subnet_mask_val", subnet_mask_val, mpres);
    if (mpres) begin
      check_ip("subnet_mask", subnet_mask, msk);
    end
  endtask

  task automatic run_without_replies();
    int         n;
    int         idx;
    int         discovers;
    logic [7:0] mtype;
    bit         seen_frame;
    bit         saw_success;
    n           = 0;
    idx         = 0;
    discovers   = 0;
    mtype       = 8'h00;
    seen_frame  = 0;
    saw_success = 0;
    pulse_start($random(seed));
    while (!fail && n < fail_wait) begin
      @(posedge clk);
      n++;
      if (frame_val) begin
        seen_frame = 1;
        if (idx == 10) begin
          mtype = frame_word[15:8];
        end
        if (frame_last) begin
          if (mtype == msg_discover) begin
            discovers++;
          end
          idx = 0;
        end else begin
          idx++;
        end
      end
      if (success && seen_frame) begin
        saw_success = 1;
      end
    end
    if (!fail) begin
      report_timeout("fail after unanswered discovers");
      return;
    end
    check_word("discover frame count", discovers, `DHCP_RETRIES + 1);
    check_flag("ready", ready, 1'b1);
    check_flag("success", saw_success, 1'b0);
  endtask

  task automatic end_test(input int num, input string name, input int err0);
    tests_run++;
    if (errors == err0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - err0);
    end
  endtask

  initial begin
    int err0;
    int i;
    bit rp;
    bit mp;
    seed         = 32'h84d9_70dd;
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    aborted      = 0;
    rst            <= 1'b1;
    start          <= 1'b0;
    pref_ip        <= '0;
    rx_val         <= 1'b0;
    rx_op          <= op_boot_reply;
    rx_xid         <= '0;
    rx_msg_type    <= msg_offer;
    rx_yiaddr      <= '0;
    rx_siaddr      <= '0;
    rx_router_pres <= 1'b0;
    rx_router      <= '0;
    rx_mask_pres   <= 1'b0;
    rx_mask        <= '0;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);

    err0 = errors;
    check_flag("frame_val", frame_val, 1'b0);
    check_flag("frame_last", frame_last, 1'b0);
    check_flag("success", success, 1'b0);
    check_flag("fail", fail, 1'b0);
    check_flag("ready", ready, 1'b0);
    check_flag("router_val", router_val, 1'b0);
    check_flag("subnet_mask_val", subnet_mask_val, 1'b0);
    run_lease(1'b0, 1'b1, 1'b1);
    end_test(1, "full lease", err0);

    // flags must drop after the previous lease had both
    if (!aborted) begin
      err0 = errors;
      run_lease(1'b0, 1'b0, 1'b0);
      for (i = 0; i < 3 && !aborted; i++) begin
        rp = $random(seed);
        mp = $random(seed);
        run_lease(1'b0, rp, mp);
      end
      end_test(2, "router and mask", err0);
    end

    if (!aborted) begin
      err0 = errors;
      rp = $random(seed);
      mp = $random(seed);
      run_lease(1'b1, rp, mp);
      end_test(3, "spurious replies", err0);
    end

    if (!aborted) begin
      err0 = errors;
      run_without_replies();
      end_test(4, "retries then fail", err0);
    end

    if (!aborted) begin
      err0 = errors;
      rp = $random(seed);
      mp = $random(seed);
      run_lease(1'b0, rp, mp);
      end_test(5, "restart after fail", err0);
    end

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
